/* source/warp_pkg.sv */
package warp_pkg;

    localparam int num_warps    = 4;
    localparam int num_threads  = 4;
    localparam int num_barriers = 2;
    localparam int nw_bits      = 2;
    localparam int nb_bits      = 1;
    localparam int pc_bits      = 32;

    localparam logic [pc_bits-1:0] startup_addr = 32'h80000000;

    // twice num_threads, enough for full nesting
    localparam int stack_depth = 8;
    localparam int stack_bits  = 3;

    // one stack entry is {pc, tmask}
    localparam int entry_bits = pc_bits + num_threads;

    typedef enum logic [2:0] {
        ctl_resume  = 3'd0,
        ctl_tmc     = 3'd1,
        ctl_wspawn  = 3'd2,
        ctl_split   = 3'd3,
        ctl_join    = 3'd4,
        ctl_barrier = 3'd5
    } ctl_op_e;

endpackage

/* source/warp_ctl_decode.sv */
module warp_ctl_decode (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              ctl_valid,
    input  warp_pkg::ctl_op_e                 ctl_op,
    input  logic [warp_pkg::nw_bits-1:0]      ctl_wid,
    input  logic [warp_pkg::num_threads-1:0]  ctl_tmask,
    input  logic [warp_pkg::num_threads-1:0]  ctl_else_tmask,
    input  logic [warp_pkg::pc_bits-1:0]      ctl_pc,
    input  logic [warp_pkg::num_threads-1:0]  cur_tmask,
    output logic [warp_pkg::num_warps-1:0]    push,
    output logic [warp_pkg::num_warps-1:0]    pop,
    output logic                              pair,
    output logic [warp_pkg::entry_bits-1:0]   q_end,
    output logic [warp_pkg::entry_bits-1:0]   q_else,
    output logic                              tmc_en,
    output logic                              wspawn_en,
    output logic                              split_en,
    output logic                              join_en,
    output logic                              barrier_en,
    output logic                              release_en,
    output logic [warp_pkg::nw_bits-1:0]      dec_wid
);

    logic                           op_known;
    logic                           op_fault;
    logic                           cmd_ok;
    logic [warp_pkg::num_warps-1:0] wid_onehot;

    assign op_known = ctl_op inside {warp_pkg::ctl_resume, warp_pkg::ctl_tmc,
                                     warp_pkg::ctl_wspawn, warp_pkg::ctl_split,
                                     warp_pkg::ctl_join, warp_pkg::ctl_barrier};

    // unknown opcode is a no-op; later commands are dropped until a resume
    always_ff @(posedge clk) begin
        if (reset) begin
            op_fault <= 1'b0;
        end else if (ctl_valid) begin
            if (!op_known) begin
                op_fault <= 1'b1;
            end else if (ctl_op == warp_pkg::ctl_resume) begin
                op_fault <= 1'b0;
            end
        end
    end

    assign cmd_ok = ctl_valid && op_known && !op_fault;

    assign tmc_en     = cmd_ok && (ctl_op == warp_pkg::ctl_tmc);
    assign wspawn_en  = cmd_ok && (ctl_op == warp_pkg::ctl_wspawn);
    assign split_en   = cmd_ok && (ctl_op == warp_pkg::ctl_split);
    assign join_en    = cmd_ok && (ctl_op == warp_pkg::ctl_join);
    assign barrier_en = cmd_ok && (ctl_op == warp_pkg::ctl_barrier);

    // any command un-stalls the warp it names
    assign release_en = ctl_valid;
    assign dec_wid    = ctl_wid;

    always_comb begin
        wid_onehot          = '0;
        wid_onehot[ctl_wid] = 1'b1;
    end

    assign push = split_en ? wid_onehot : '0;
    assign pop  = join_en ? wid_onehot : '0;

    // diverged only when both sides have threads
    assign pair   = (ctl_tmask != '0) && (ctl_else_tmask != '0);
    assign q_end  = {{warp_pkg::pc_bits{1'b0}}, cur_tmask};
    assign q_else = {ctl_pc, ctl_else_tmask};

endmodule

/* source/ipdom_stack.sv */
module ipdom_stack (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             push,
    input  logic                             pop,
    input  logic                             pair,
    input  logic [warp_pkg::entry_bits-1:0]  q1,
    input  logic [warp_pkg::entry_bits-1:0]  q2,
    output logic [warp_pkg::entry_bits-1:0]  d,
    output logic                             index,
    output logic                             empty
);

    logic [warp_pkg::entry_bits-1:0] entries [warp_pkg::stack_depth];
    logic                            is_else [warp_pkg::stack_depth];

    // fill level, one bit wider than an address
    logic [warp_pkg::stack_bits:0]   count;
    logic [warp_pkg::stack_bits-1:0] wr_addr;
    logic [warp_pkg::stack_bits-1:0] top_addr;

    assign wr_addr  = count[warp_pkg::stack_bits-1:0];
    assign top_addr = wr_addr - 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (push) begin
            count <= count + (pair ? 2'd2 : 2'd1);
        end else if (pop) begin
            count <= count - 1'b1;
        end
    end

    // end entry goes below the else entry
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_addr] <= q1;
            is_else[wr_addr] <= 1'b0;
            if (pair) begin
                entries[wr_addr + 1'b1] <= q2;
                is_else[wr_addr + 1'b1] <= 1'b1;
            end
        end
    end

    assign d     = entries[top_addr];
    assign index = is_else[top_addr];
    assign empty = (count == '0);

endmodule

/* source/warp_sched.sv */
module warp_sched (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  tmc_en,
    input  logic                                                  wspawn_en,
    input  logic                                                  split_en,
    input  logic                                                  join_en,
    input  logic                                                  barrier_en,
    input  logic                                                  release_en,
    input  logic [warp_pkg::nw_bits-1:0]                          dec_wid,
    input  logic [warp_pkg::num_threads-1:0]                      ctl_tmask,
    input  logic [warp_pkg::pc_bits-1:0]                          ctl_pc,
    input  logic [warp_pkg::num_warps-1:0]                        ctl_wmask,
    input  logic [warp_pkg::nb_bits-1:0]                          ctl_bar_id,
    input  logic [warp_pkg::nw_bits-1:0]                          ctl_bar_size_m1,
    input  logic [warp_pkg::num_warps-1:0][warp_pkg::entry_bits-1:0] stack_top,
    input  logic [warp_pkg::num_warps-1:0]                        stack_index,
    input  logic                                                  branch_valid,
    input  logic [warp_pkg::nw_bits-1:0]                          branch_wid,
    input  logic                                                  branch_taken,
    input  logic [warp_pkg::pc_bits-1:0]                          branch_dest,
    input  logic                                                  fetch_ready,
    output logic                                                  fetch_valid,
    output logic [warp_pkg::nw_bits-1:0]                          fetch_wid,
    output logic [warp_pkg::num_threads-1:0]                      fetch_tmask,
    output logic [warp_pkg::pc_bits-1:0]                          fetch_pc,
    output logic [warp_pkg::num_threads-1:0]                      cur_tmask,
    output logic                                                  busy
);

    logic [warp_pkg::num_warps-1:0]                           active_warps;
    logic [warp_pkg::num_warps-1:0]                           stalled_warps;
    logic [warp_pkg::num_warps-1:0]                           use_wspawn;
    logic [warp_pkg::num_warps-1:0][warp_pkg::num_threads-1:0] thread_masks;
    logic [warp_pkg::num_warps-1:0][warp_pkg::pc_bits-1:0]     warp_pcs;
    logic [warp_pkg::num_barriers-1:0][warp_pkg::num_warps-1:0] barrier_masks;
    logic [warp_pkg::pc_bits-1:0]                             wspawn_pc;

    logic [warp_pkg::nw_bits:0]       bar_count;
    logic                             bar_reached;
    logic [warp_pkg::num_warps-1:0]   barrier_stalls;
    logic [warp_pkg::num_warps-1:0]   ready_warps;
    logic [warp_pkg::nw_bits-1:0]     sched_wid;
    logic                             sched_valid;
    logic [warp_pkg::num_threads-1:0] sched_tmask;
    logic [warp_pkg::pc_bits-1:0]     sched_pc;
    logic                             stall_out;
    logic                             warp_scheduled;
    logic                             fetch_fire;
    logic [warp_pkg::entry_bits-1:0]  join_entry;

    assign cur_tmask   = thread_masks[dec_wid];
    assign join_entry  = stack_top[dec_wid];
    assign fetch_fire  = fetch_valid && fetch_ready;

    // warps already waiting on the addressed barrier
    always_comb begin
        bar_count = '0;
        for (int i = 0; i < warp_pkg::num_warps; i++) begin
            bar_count = bar_count + {{warp_pkg::nw_bits{1'b0}}, barrier_masks[ctl_bar_id][i]};
        end
    end

    assign bar_reached = (bar_count == {1'b0, ctl_bar_size_m1});

    always_comb begin
        barrier_stalls = '0;
        for (int b = 0; b < warp_pkg::num_barriers; b++) begin
            barrier_stalls = barrier_stalls | barrier_masks[b];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_warps    <= '0;
            active_warps[0] <= 1'b1;
            stalled_warps   <= '0;
            use_wspawn      <= '0;
            thread_masks    <= '0;
            thread_masks[0] <= {{(warp_pkg::num_threads-1){1'b0}}, 1'b1};
            warp_pcs        <= '0;
            warp_pcs[0]     <= warp_pkg::startup_addr;
            barrier_masks   <= '0;
        end else begin
            if (wspawn_en) begin
                active_warps  <= ctl_wmask;
                use_wspawn    <= ctl_wmask & ~{{(warp_pkg::num_warps-1){1'b0}}, 1'b1};
                stalled_warps <= stalled_warps & ~ctl_wmask;
            end
            if (tmc_en) begin
                thread_masks[dec_wid] <= ctl_tmask;
                active_warps[dec_wid] <= (ctl_tmask != '0);
            end
            if (split_en && ctl_tmask != '0) begin
                thread_masks[dec_wid] <= ctl_tmask;
            end
            if (barrier_en) begin
                if (bar_reached) begin
                    barrier_masks[ctl_bar_id] <= '0;
                end else begin
                    barrier_masks[ctl_bar_id][dec_wid] <= 1'b1;
                end
            end
            if (release_en) begin
                stalled_warps[dec_wid] <= 1'b0;
            end
            if (branch_valid) begin
                stalled_warps[branch_wid] <= 1'b0;
            end

            // held until the next command or branch for this warp
            if (warp_scheduled) begin
                stalled_warps[sched_wid] <= 1'b1;
                use_wspawn[sched_wid]    <= 1'b0;
                if (use_wspawn[sched_wid]) begin
                    thread_masks[sched_wid] <= {{(warp_pkg::num_threads-1){1'b0}}, 1'b1};
                end
            end

            if (fetch_fire) begin
                warp_pcs[fetch_wid] <= fetch_pc + 32'd4;
            end
            if (branch_valid && branch_taken) begin
                warp_pcs[branch_wid] <= branch_dest;
            end

            // else entry restores pc and mask, end entry the mask only
            if (join_en) begin
                thread_masks[dec_wid] <= join_entry[warp_pkg::num_threads-1:0];
                if (stack_index[dec_wid]) begin
                    warp_pcs[dec_wid] <= join_entry[warp_pkg::entry_bits-1:warp_pkg::num_threads];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wspawn_en) begin
            wspawn_pc <= ctl_pc;
        end
    end

    assign ready_warps = active_warps & ~(stalled_warps | barrier_stalls);
    assign sched_valid = (ready_warps != '0);

    // lowest id wins
    always_comb begin
        sched_wid = '0;
        for (int i = warp_pkg::num_warps - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                sched_wid = i[warp_pkg::nw_bits-1:0];
            end
        end
    end

    assign sched_tmask = use_wspawn[sched_wid] ? {{(warp_pkg::num_threads-1){1'b0}}, 1'b1}
                                               : thread_masks[sched_wid];
    assign sched_pc    = use_wspawn[sched_wid] ? wspawn_pc : warp_pcs[sched_wid];

    assign stall_out      = fetch_valid && !fetch_ready;
    assign warp_scheduled = sched_valid && !stall_out;

    // fetch request register
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid <= 1'b0;
        end else if (!stall_out) begin
            fetch_valid <= sched_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_out) begin
            fetch_wid   <= sched_wid;
            fetch_tmask <= sched_tmask;
            fetch_pc    <= sched_pc;
        end
    end

    assign busy = (active_warps != '0);

endmodule

/* source/warp_sched_top.sv */
module warp_sched_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              ctl_valid,
    input  warp_pkg::ctl_op_e                 ctl_op,
    input  logic [warp_pkg::nw_bits-1:0]      ctl_wid,
    input  logic [warp_pkg::num_threads-1:0]  ctl_tmask,
    input  logic [warp_pkg::num_threads-1:0]  ctl_else_tmask,
    input  logic [warp_pkg::pc_bits-1:0]      ctl_pc,
    input  logic [warp_pkg::num_warps-1:0]    ctl_wmask,
    input  logic [warp_pkg::nb_bits-1:0]      ctl_bar_id,
    input  logic [warp_pkg::nw_bits-1:0]      ctl_bar_size_m1,
    input  logic                              branch_valid,
    input  logic [warp_pkg::nw_bits-1:0]      branch_wid,
    input  logic                              branch_taken,
    input  logic [warp_pkg::pc_bits-1:0]      branch_dest,
    output logic                              fetch_valid,
    output logic [warp_pkg::nw_bits-1:0]      fetch_wid,
    output logic [warp_pkg::num_threads-1:0]  fetch_tmask,
    output logic [warp_pkg::pc_bits-1:0]      fetch_pc,
    input  logic                              fetch_ready,
    output logic                              busy
);

    logic [warp_pkg::num_warps-1:0]                           push;
    logic [warp_pkg::num_warps-1:0]                           pop;
    logic                                                     pair;
    logic [warp_pkg::entry_bits-1:0]                          q_end;
    logic [warp_pkg::entry_bits-1:0]                          q_else;
    logic                                                     tmc_en;
    logic                                                     wspawn_en;
    logic                                                     split_en;
    logic                                                     join_en;
    logic                                                     barrier_en;
    logic                                                     release_en;
    logic [warp_pkg::nw_bits-1:0]                             dec_wid;
    logic [warp_pkg::num_threads-1:0]                         cur_tmask;
    logic [warp_pkg::num_warps-1:0][warp_pkg::entry_bits-1:0] stack_top;
    logic [warp_pkg::num_warps-1:0]                           stack_index;

    warp_ctl_decode u_decode (
        .clk            (clk),
        .reset          (reset),
        .ctl_valid      (ctl_valid),
        .ctl_op         (ctl_op),
        .ctl_wid        (ctl_wid),
        .ctl_tmask      (ctl_tmask),
        .ctl_else_tmask (ctl_else_tmask),
        .ctl_pc         (ctl_pc),
        .cur_tmask      (cur_tmask),
        .push           (push),
        .pop            (pop),
        .pair           (pair),
        .q_end          (q_end),
        .q_else         (q_else),
        .tmc_en         (tmc_en),
        .wspawn_en      (wspawn_en),
        .split_en       (split_en),
        .join_en        (join_en),
        .barrier_en     (barrier_en),
        .release_en     (release_en),
        .dec_wid        (dec_wid)
    );

    // one divergence stack per warp
    for (genvar i = 0; i < warp_pkg::num_warps; i++) begin : g_stack
        ipdom_stack u_stack (
            .clk   (clk),
            .reset (reset),
            .push  (push[i]),
            .pop   (pop[i]),
            .pair  (pair),
            .q1    (q_end),
            .q2    (q_else),
            .d     (stack_top[i]),
            .index (stack_index[i]),
            .empty ()
        );
    end

    warp_sched u_sched (
        .clk             (clk),
        .reset           (reset),
        .tmc_en          (tmc_en),
        .wspawn_en       (wspawn_en),
        .split_en        (split_en),
        .join_en         (join_en),
        .barrier_en      (barrier_en),
        .release_en      (release_en),
        .dec_wid         (dec_wid),
        .ctl_tmask       (ctl_tmask),
        .ctl_pc          (ctl_pc),
        .ctl_wmask       (ctl_wmask),
        .ctl_bar_id      (ctl_bar_id),
        .ctl_bar_size_m1 (ctl_bar_size_m1),
        .stack_top       (stack_top),
        .stack_index     (stack_index),
        .branch_valid    (branch_valid),
        .branch_wid      (branch_wid),
        .branch_taken    (branch_taken),
        .branch_dest     (branch_dest),
        .fetch_ready     (fetch_ready),
        .fetch_valid     (fetch_valid),
        .fetch_wid       (fetch_wid),
        .fetch_tmask     (fetch_tmask),
        .fetch_pc        (fetch_pc),
        .cur_tmask       (cur_tmask),
        .busy            (busy)
    );

endmodule

/* bench/warp_sched_sva.sv */
module warp_sched_sva (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 fetch_valid,
    input logic                                 fetch_ready,
    input logic [warp_pkg::nw_bits-1:0]         fetch_wid,
    input logic [warp_pkg::num_threads-1:0]     fetch_tmask,
    input logic [warp_pkg::pc_bits-1:0]         fetch_pc,
    input logic [warp_pkg::num_warps-1:0]       active_warps
);
    timeunit 1ns;
    timeprecision 1ps;

    // no request straight out of reset
    assert property (@(posedge clk) reset |=> !fetch_valid)
        else $error("fetch_valid high after reset");

    // held request keeps its fields
    assert property (@(posedge clk) disable iff (reset)
        fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_wid) &&
            $stable(fetch_tmask) && $stable(fetch_pc))
        else $error("fetch request changed while stalled");

    // transfers only for live warps
    assert property (@(posedge clk) disable iff (reset)
        fetch_valid && fetch_ready |-> active_warps[fetch_wid])
        else $error("fetch transfer for an inactive warp");

endmodule

bind warp_sched warp_sched_sva u_sva (
    .clk          (clk),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .fetch_ready  (fetch_ready),
    .fetch_wid    (fetch_wid),
    .fetch_tmask  (fetch_tmask),
    .fetch_pc     (fetch_pc),
    .active_warps (active_warps)
);

/* bench/warp_sched_tb.sv */
module warp_sched_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum {row_idle, row_ctl, row_branch} kind_e;

    typedef struct {
        kind_e             kind;
        warp_pkg::ctl_op_e op;
        logic [1:0]        wid;
        logic [3:0]        tmask;
        logic [3:0]        else_tmask;
        logic [31:0]       pc;
        logic [3:0]        wmask;
        logic [1:0]        size_m1;
        logic              taken;
        int                none_cycles;
        logic [1:0]        exp_wid;
        logic [3:0]        exp_tmask;
        logic [31:0]       exp_pc;
        logic              exp_busy;
    } row_t;

    logic clk;
    logic reset;
    logic ctl_valid;
    warp_pkg::ctl_op_e ctl_op;
    logic [warp_pkg::nw_bits-1:0]     ctl_wid;
    logic [warp_pkg::num_threads-1:0] ctl_tmask;
    logic [warp_pkg::num_threads-1:0] ctl_else_tmask;
    logic [warp_pkg::pc_bits-1:0]     ctl_pc;
    logic [warp_pkg::num_warps-1:0]   ctl_wmask;
    logic [warp_pkg::nb_bits-1:0]     ctl_bar_id;
    logic [warp_pkg::nw_bits-1:0]     ctl_bar_size_m1;
    logic                             branch_valid;
    logic [warp_pkg::nw_bits-1:0]     branch_wid;
    logic                             branch_taken;
    logic [warp_pkg::pc_bits-1:0]     branch_dest;
    logic                             fetch_valid;
    logic [warp_pkg::nw_bits-1:0]     fetch_wid;
    logic [warp_pkg::num_threads-1:0] fetch_tmask;
    logic [warp_pkg::pc_bits-1:0]     fetch_pc;
    logic                             fetch_ready;
    logic                             busy;

    row_t rows[$];
    logic rows_ready = 1'b0;
    int   row_num;
    int   checks = 0;
    int   errors = 0;

    warp_sched_top DUT (
        .clk             (clk),
        .reset           (reset),
        .ctl_valid       (ctl_valid),
        .ctl_op          (ctl_op),
        .ctl_wid         (ctl_wid),
        .ctl_tmask       (ctl_tmask),
        .ctl_else_tmask  (ctl_else_tmask),
        .ctl_pc          (ctl_pc),
        .ctl_wmask       (ctl_wmask),
        .ctl_bar_id      (ctl_bar_id),
        .ctl_bar_size_m1 (ctl_bar_size_m1),
        .branch_valid    (branch_valid),
        .branch_wid      (branch_wid),
        .branch_taken    (branch_taken),
        .branch_dest     (branch_dest),
        .fetch_valid     (fetch_valid),
        .fetch_wid       (fetch_wid),
        .fetch_tmask     (fetch_tmask),
        .fetch_pc        (fetch_pc),
        .fetch_ready     (fetch_ready),
        .busy            (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: row %0d %s = 0x%h, expected 0x%h", row_num, name, actual,
                     expected);
        end
    endtask

    task automatic add_row(input kind_e kind, input warp_pkg::ctl_op_e op,
                           input logic [1:0] wid, input logic [3:0] tmask,
                           input logic [3:0] else_tmask, input logic [31:0] pc,
                           input logic [3:0] wmask, input logic [1:0] size_m1,
                           input logic taken, input int none_cycles,
                           input logic [1:0] exp_wid, input logic [3:0] exp_tmask,
                           input logic [31:0] exp_pc, input logic exp_busy);
        row_t r;
        r.kind        = kind;
        r.op          = op;
        r.wid         = wid;
        r.tmask       = tmask;
        r.else_tmask  = else_tmask;
        r.pc          = pc;
        r.wmask       = wmask;
        r.size_m1     = size_m1;
        r.taken       = taken;
        r.none_cycles = none_cycles;
        r.exp_wid     = exp_wid;
        r.exp_tmask   = exp_tmask;
        r.exp_pc      = exp_pc;
        r.exp_busy    = exp_busy;
        rows.push_back(r);
    endtask

    // kind, op, wid, tmask, else, pc, wmask, size_m1, taken | none, wid, tmask, pc, busy
    task automatic build_table();
        add_row(row_idle, warp_pkg::ctl_resume, 0, 4'h0, 4'h0, 32'h0, 4'h0, 0, 0,
                0, 0, 4'h1, 32'h80000000, 1);
        add_row(row_ctl, warp_pkg::ctl_resume, 0, 4'h0, 4'h0, 32'h0, 4'h0, 0, 0,
                0, 0, 4'h1, 32'h80000004, 1);
        // spawned warps start at the spawn pc on lane 0
        add_row(row_ctl, warp_pkg::ctl_wspawn, 0, 4'h0, 4'h0, 32'h1000, 4'hf, 0, 0,
                0, 0, 4'h1, 32'h80000008, 1);
        add_row(row_idle, warp_pkg::ctl_resume, 0, 4'h0, 4'h0, 32'h0, 4'h0, 0, 0,
                0, 1, 4'h1, 32'h1000, 1);
        add_row(row_idle, warp_pkg::ctl_resume, 0, 4'h0, 4'h0, 32'h0, 4'h0, 0, 0,
                0, 2, 4'h1, 32'h1000, 1);
        add_row(row_idle, warp_pkg::ctl_resume, 0, 4'h0, 4'h0, 32'h0, 4'h0, 0, 0,
                0, 3, 4'h1, 32'h1000, 1);
        add_row(row_ctl, warp_pkg::ctl_tmc, 0, 4'hf, 4'h0, 32'h0, 4'h0, 0, 0,
                0, 0, 4'hf, 32'h8000000c, 1);
        // then side first, else side from the first join, full mask on the second
        add_row(row_ctl, warp_pkg::ctl_split, 0, 4'h3, 4'hc, 32'h2000, 4'h0, 0, 0,
                0, 0, 4'h3, 32'h80000010, 1);
        add_row(row_ctl, warp_pkg::ctl_join, 0, 4'h0, 4'h0, 32'h0, 4'h0, 0, 0,
                0, 0, 4'hc, 32'h2000, 1);
        add_row(row_ctl, warp_pkg::ctl_join, 0, 4'h0, 4'h0, 32'h0, 4'h0, 0, 0,
                0, 0, 4'hf, 32'h2004, 1);
        add_row(row_branch, warp_pkg::ctl_resume, 0, 4'h0, 4'h0, 32'h3000, 4'h0, 0, 1,
                0, 0, 4'hf, 32'h3000, 1);
        add_row(row_branch, warp_pkg::ctl_resume, 0, 4'h0, 4'h0, 32'h4000, 4'h0, 0, 0,
                0, 0, 4'hf, 32'h3004, 1);
        // two-warp barrier
        add_row(row_ctl, warp_pkg::ctl_barrier, 1, 4'h0, 4'h0, 32'h0, 4'h0, 1, 0,
                8, 0, 4'h0, 32'h0, 1);
        add_row(row_ctl, warp_pkg::ctl_barrier, 2, 4'h0, 4'h0, 32'h0, 4'h0, 1, 0,
                0, 1, 4'h1, 32'h1004, 1);
        add_row(row_idle, warp_pkg::ctl_resume, 0, 4'h0, 4'h0, 32'h0, 4'h0, 0, 0,
                0, 2, 4'h1, 32'h1004, 1);
        add_row(row_ctl, warp_pkg::ctl_tmc, 0, 4'h0, 4'h0, 32'h0, 4'h0, 0, 0,
                4, 0, 4'h0, 32'h0, 1);
        add_row(row_ctl, warp_pkg::ctl_tmc, 1, 4'h0, 4'h0, 32'h0, 4'h0, 0, 0,
                4, 0, 4'h0, 32'h0, 1);
        add_row(row_ctl, warp_pkg::ctl_tmc, 2, 4'h0, 4'h0, 32'h0, 4'h0, 0, 0,
                4, 0, 4'h0, 32'h0, 1);
        add_row(row_ctl, warp_pkg::ctl_tmc, 3, 4'h0, 4'h0, 32'h0, 4'h0, 0, 0,
                8, 0, 4'h0, 32'h0, 0);
    endtask

    task automatic next_cycle();
        @(negedge clk);
        fetch_ready = ($urandom % 4) != 0;
    endtask

    task automatic drive_row(input row_t r);
        if (r.kind == row_ctl) begin
            ctl_valid       = 1'b1;
            ctl_op          = r.op;
            ctl_wid         = r.wid;
            ctl_tmask       = r.tmask;
            ctl_else_tmask  = r.else_tmask;
            ctl_pc          = r.pc;
            ctl_wmask       = r.wmask;
            ctl_bar_id      = '0;
            ctl_bar_size_m1 = r.size_m1;
        end else if (r.kind == row_branch) begin
            branch_valid = 1'b1;
            branch_wid   = r.wid;
            branch_taken = r.taken;
            branch_dest  = r.pc;
        end
    endtask

    task automatic run_row(input row_t r);
        int          cycles;
        logic        done;
        logic        held;
        logic [1:0]  held_wid;
        logic [3:0]  held_tmask;
        logic [31:0] held_pc;
        cycles = 0;
        done   = 1'b0;
        held   = 1'b0;
        drive_row(r);
        while (!done) begin
            if (r.none_cycles > 0) begin
                check_value("fetch_valid", 32'(fetch_valid), 32'd0);
                cycles++;
                done = (cycles == r.none_cycles);
            end else if (fetch_valid && fetch_ready) begin
                if (held) begin
                    check_value("fetch_wid", 32'(fetch_wid), 32'(held_wid));
                    check_value("fetch_tmask", 32'(fetch_tmask), 32'(held_tmask));
                    check_value("fetch_pc", fetch_pc, held_pc);
                end
                check_value("fetch_wid", 32'(fetch_wid), 32'(r.exp_wid));
                check_value("fetch_tmask", 32'(fetch_tmask), 32'(r.exp_tmask));
                check_value("fetch_pc", fetch_pc, r.exp_pc);
                done = 1'b1;
            end else if (fetch_valid && !held) begin
                held       = 1'b1;
                held_wid   = fetch_wid;
                held_tmask = fetch_tmask;
                held_pc    = fetch_pc;
            end
            next_cycle();
            ctl_valid    = 1'b0;
            branch_valid = 1'b0;
            // command has reached warp state by now
            check_value("busy", 32'(busy), 32'(r.exp_busy));
        end
    endtask

    initial begin
        void'($urandom(32'ha6f7));
        reset           = 1'b1;
        fetch_ready     = 1'b0;
        ctl_valid       = 1'b0;
        ctl_op          = warp_pkg::ctl_resume;
        ctl_wid         = '0;
        ctl_tmask       = '0;
        ctl_else_tmask  = '0;
        ctl_pc          = '0;
        ctl_wmask       = '0;
        ctl_bar_id      = '0;
        ctl_bar_size_m1 = '0;
        branch_valid    = 1'b0;
        branch_wid      = '0;
        branch_taken    = 1'b0;
        branch_dest     = '0;
        build_table();
        rows_ready = 1'b1;
        repeat (8) @(posedge clk);
        next_cycle();
        reset = 1'b0;
        foreach (rows[i]) begin
            row_num = i;
            run_row(rows[i]);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // 200 cycles per table row plus reset
    initial begin
        wait (rows_ready);
        repeat (rows.size() * 200 + 8) @(posedge clk);
        $display("watchdog expired before all table rows completed");
        $display("Some tests failed");
        $finish;
    end

endmodule

/* files.f */
source/warp_pkg.sv
source/warp_ctl_decode.sv
source/ipdom_stack.sv
source/warp_sched.sv
source/warp_sched_top.sv
bench/warp_sched_sva.sv
bench/warp_sched_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module warp_sched_tb -f files.f
	@out="$$(./obj_dir/Vwarp_sched_tb)"; echo "$$out"; \
		echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
